//--- src/tlb_pkg.sv
// Shared constants and packed records for the data TLB.
// Every pipeline stage and the client port use these types.
`default_nettype none

package tlb_pkg;

  localparam int way_count = 8;
  localparam int way_bits  = 3;  // Width of a way number and of an LRU rank.

  typedef logic [35:0] vpn_t;
  typedef logic [11:0] asid_t;

  // Page table entry as seen by the TLB.
  typedef struct packed {
    logic [27:0] ppn;
    logic        glob;      // Global page, matches under any asid.
    logic        writable;
    logic        user;
    logic        exec;
  } pte_t;

  typedef enum logic [1:0] {
    op_lookup = 2'd0,
    op_fill   = 2'd1,
    op_inval  = 2'd2
  } tlb_op_e;

  typedef struct packed {
    tlb_op_e op;
    vpn_t    vpn;
    asid_t   asid;
    pte_t    pte;  // Only a fill looks at this.
  } tlb_req_t;

  typedef struct packed {
    logic                hit;
    logic [way_bits-1:0] way;
    pte_t                pte;
  } tlb_rsp_t;

  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
    asid_t asid;
    pte_t  pte;
  } tlb_entry_t;

  // One rank per way. Rank 7 marks the oldest way of the set.
  typedef logic [way_count-1:0][way_bits-1:0] lru_set_t;

  typedef struct packed {
    tlb_req_t            req;
    logic                hit;
    logic [way_bits-1:0] hit_way;
    pte_t                pte;
    lru_set_t            ranks;
    logic [way_bits-1:0] victim;
  } tlb_lookup_t;

  typedef struct packed {
    logic [way_count-1:0] way_we;  // One-hot way select.
    tlb_entry_t           entry;
    logic                 lru_we;
    lru_set_t             ranks;
  } tlb_write_t;

endpackage

`default_nettype wire

//--- src/tlb_set_ram.sv
// Set-indexed storage with a combinational read and a clocked write.
`default_nettype none

module tlb_set_ram #(
  parameter type entry_t = logic,
  parameter int  sets    = 16
) (
  input  logic                    clk,
  input  logic [$clog2(sets)-1:0] rd_idx,
  output entry_t                  rd_data,
  input  logic                    wr_en,
  input  logic [$clog2(sets)-1:0] wr_idx,
  input  entry_t                  wr_data
);

  entry_t mem [sets];

  // The read sees the old contents until the write edge.
  assign rd_data = mem[rd_idx];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_idx] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- src/tlb_way.sv
// One TLB way: an entry store per set plus the tag compare for the current
// request, with the global flag overriding the asid compare.
`default_nettype none

module tlb_way #(
  parameter int sets = 16
) (
  input  logic                    clk,
  input  tlb_pkg::tlb_req_t       query,
  output logic                    hit,
  output tlb_pkg::pte_t           pte,
  input  logic                    wr_en,
  input  logic [$clog2(sets)-1:0] wr_idx,
  input  tlb_pkg::tlb_entry_t     wr_entry
);

  localparam int idx_bits = $clog2(sets);

  tlb_pkg::tlb_entry_t entry;
  logic                asid_ok;
  logic                vpn_ok;

  tlb_set_ram #(
    .entry_t (tlb_pkg::tlb_entry_t),
    .sets    (sets)
  ) entry_ram_i (
    .clk     (clk),
    .rd_idx  (query.vpn[idx_bits-1:0]),
    .rd_data (entry),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_data (wr_entry)
  );

  assign vpn_ok  = (entry.vpn == query.vpn);
  assign asid_ok = (entry.asid == query.asid) || entry.pte.glob;

  assign hit = entry.valid && vpn_ok && asid_ok;

  // A way that misses drives zero, so the lookup stage can OR all ways.
  assign pte = hit ? entry.pte : '0;

endmodule

`default_nettype wire

//--- src/tlb_req_port.sv
// Four-phase req/ack front end of the TLB.
// Issues one request per handshake and holds the response while ack is high.
`default_nettype none

module tlb_req_port (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  tlb_pkg::tlb_req_t req_data,
  output logic              ack,
  output tlb_pkg::tlb_rsp_t rsp_data,
  input  logic              init_busy,
  output logic              issue_valid,
  output tlb_pkg::tlb_req_t issue,
  input  logic              done_valid,
  input  tlb_pkg::tlb_rsp_t done_rsp
);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_ack
  } state_e;

  state_e state;
  logic   take;

  // A new request is only accepted once the init sweep is over.
  assign take = (state == st_idle) && req && !init_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      ack         <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= take;  // One-cycle pulse.
      case (state)
        st_idle: begin
          if (take) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (done_valid) begin
            state <= st_ack;
            ack   <= 1'b1;
          end
        end
        st_ack: begin
          // The client has seen ack once req falls.
          if (!req) begin
            state <= st_idle;
            ack   <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Request and response payloads.
  always_ff @(posedge clk) begin
    if (take) begin
      issue <= req_data;
    end
    if (state == st_wait && done_valid) begin
      rsp_data <= done_rsp;  // Held for the whole ack phase.
    end
  end

endmodule

`default_nettype wire

//--- src/tlb_lookup_stage.sv
// Lookup stage: reads all ways and the LRU ranks of the set, finds the hit
// and the victim, and registers the result for the update stage.
`default_nettype none

module tlb_lookup_stage #(
  parameter int sets = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  tlb_pkg::tlb_req_t       in_req,
  input  logic [$clog2(sets)-1:0] wr_idx,
  input  tlb_pkg::tlb_write_t     wr,
  output logic                    out_valid,
  output tlb_pkg::tlb_lookup_t    out
);

  localparam int idx_bits = $clog2(sets);

  logic [tlb_pkg::way_count-1:0]                way_hit;
  tlb_pkg::pte_t [tlb_pkg::way_count-1:0]       way_pte;
  tlb_pkg::lru_set_t                            ranks;
  tlb_pkg::tlb_lookup_t                         res;

  for (genvar k = 0; k < tlb_pkg::way_count; k++) begin : g_way
    tlb_way #(
      .sets (sets)
    ) way_i (
      .clk      (clk),
      .query    (in_req),
      .hit      (way_hit[k]),
      .pte      (way_pte[k]),
      .wr_en    (wr.way_we[k]),
      .wr_idx   (wr_idx),
      .wr_entry (wr.entry)
    );
  end

  // Rank store, one lru_set_t per set.
  tlb_set_ram #(
    .entry_t (tlb_pkg::lru_set_t),
    .sets    (sets)
  ) rank_ram_i (
    .clk     (clk),
    .rd_idx  (in_req.vpn[idx_bits-1:0]),
    .rd_data (ranks),
    .wr_en   (wr.lru_we),
    .wr_idx  (wr_idx),
    .wr_data (wr.ranks)
  );

  // At most one way hits, so the way number and pte are plain ORs of the
  // one-hot vector. A miss leaves both at zero.
  always_comb begin
    res       = '0;
    res.req   = in_req;
    res.hit   = |way_hit;
    res.ranks = ranks;
    for (int k = 0; k < tlb_pkg::way_count; k++) begin
      if (way_hit[k]) begin
        res.hit_way = res.hit_way | k[tlb_pkg::way_bits-1:0];
      end
      res.pte = res.pte | way_pte[k];
      // Ranks form a permutation, so exactly one way holds rank 7.
      if (&ranks[k]) begin
        res.victim = k[tlb_pkg::way_bits-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out <= res;
    end
  end

endmodule

`default_nettype wire

//--- src/tlb_update_stage.sv
// Update stage: applies fill, lookup and invalidate to entries and ranks,
// forms the response, and sweeps every set after reset.
`default_nettype none

module tlb_update_stage #(
  parameter int sets = 16
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_valid,
  input  tlb_pkg::tlb_lookup_t    in,
  output logic [$clog2(sets)-1:0] wr_idx,
  output tlb_pkg::tlb_write_t     wr,
  output logic                    init_busy,
  output logic                    out_valid,
  output tlb_pkg::tlb_rsp_t       out_rsp
);

  localparam int idx_bits = $clog2(sets);

  logic [idx_bits-1:0]          init_idx;
  logic                         is_lookup;
  logic                         is_fill;
  logic                         is_inval;
  logic [tlb_pkg::way_bits-1:0] tgt_way;
  logic [tlb_pkg::way_bits-1:0] tgt_rank;
  tlb_pkg::lru_set_t            new_ranks;
  tlb_pkg::lru_set_t            init_ranks;
  tlb_pkg::tlb_rsp_t            rsp;

  assign is_lookup = (in.req.op == tlb_pkg::op_lookup);
  assign is_fill   = (in.req.op == tlb_pkg::op_fill);
  assign is_inval  = (in.req.op == tlb_pkg::op_inval);

  // A fill that misses replaces the oldest way. Everything else acts on the hit way.
  assign tgt_way  = (is_fill && !in.hit) ? in.victim : in.hit_way;
  assign tgt_rank = in.ranks[tgt_way];

  // The target becomes rank 0 and every younger way ages by one.
  always_comb begin
    for (int k = 0; k < tlb_pkg::way_count; k++) begin
      if (k == tgt_way) begin
        new_ranks[k] = '0;
      end else if (in.ranks[k] < tgt_rank) begin
        new_ranks[k] = in.ranks[k] + 1'b1;
      end else begin
        new_ranks[k] = in.ranks[k];
      end
      init_ranks[k] = k[tlb_pkg::way_bits-1:0];  // Way k starts at rank k.
    end
  end

  always_comb begin
    wr     = '0;
    wr_idx = in.req.vpn[idx_bits-1:0];
    if (init_busy) begin
      // Clear every way of the swept set and load the starting ranks.
      wr.way_we = '1;
      wr.lru_we = 1'b1;
      wr.ranks  = init_ranks;
      wr_idx    = init_idx;
    end else begin
      wr.entry.valid = is_fill;  // An invalidate writes the entry back as invalid.
      wr.entry.vpn   = in.req.vpn;
      wr.entry.asid  = in.req.asid;
      wr.entry.pte   = is_fill ? in.req.pte : in.pte;
      wr.ranks       = new_ranks;
      if (in_valid && (is_fill || (is_inval && in.hit))) begin
        wr.way_we[tgt_way] = 1'b1;
      end
      wr.lru_we = in_valid && (is_fill || (is_lookup && in.hit));
    end
  end

  // A miss on lookup or invalidate arrives with zero way and pte already.
  always_comb begin
    rsp.hit = in.hit;
    rsp.way = tgt_way;
    rsp.pte = is_fill ? in.req.pte : in.pte;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      init_busy <= 1'b1;
      init_idx  <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (init_busy) begin
        init_idx <= init_idx + 1'b1;
        if (init_idx == idx_bits'(sets - 1)) begin
          init_busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_rsp <= rsp;
    end
  end

endmodule

`default_nettype wire

//--- src/dtlb_top.sv
// Data TLB top level with 8 ways and rank-based LRU replacement.
// Chains the req/ack port, the lookup stage and the update stage.
`default_nettype none

module dtlb_top #(
  parameter int sets = 16
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req,
  input  tlb_pkg::tlb_req_t req_data,
  output logic              ack,
  output tlb_pkg::tlb_rsp_t rsp_data
);

  logic                    init_busy;
  logic                    issue_valid;
  tlb_pkg::tlb_req_t       issue;
  logic                    lk_valid;
  tlb_pkg::tlb_lookup_t    lk;
  logic [$clog2(sets)-1:0] wr_idx;
  tlb_pkg::tlb_write_t     wr;
  logic                    done_valid;
  tlb_pkg::tlb_rsp_t       done_rsp;

  tlb_req_port port_i (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .req_data    (req_data),
    .ack         (ack),
    .rsp_data    (rsp_data),
    .init_busy   (init_busy),
    .issue_valid (issue_valid),
    .issue       (issue),
    .done_valid  (done_valid),
    .done_rsp    (done_rsp)
  );

  tlb_lookup_stage #(
    .sets (sets)
  ) lookup_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (issue_valid),
    .in_req    (issue),
    .wr_idx    (wr_idx),
    .wr        (wr),
    .out_valid (lk_valid),
    .out       (lk)
  );

  tlb_update_stage #(
    .sets (sets)
  ) update_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (lk_valid),
    .in        (lk),
    .wr_idx    (wr_idx),
    .wr        (wr),
    .init_busy (init_busy),
    .out_valid (done_valid),
    .out_rsp   (done_rsp)
  );

endmodule

`default_nettype wire

//--- sim/tb_dtlb.sv
// Directed testbench for the data TLB.
// A set/way model with LRU ranks predicts every response over the req/ack port.
`default_nettype none

module tb_dtlb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int sets         = 16;
  localparam int idx_bits     = $clog2(sets);
  localparam int ways         = tlb_pkg::way_count;
  localparam int ack_limit    = sets + 20;  // Covers the init sweep on the first request.
  localparam int n_random     = 200;
  localparam int n_handshakes = 250;        // Directed tests plus the random mix.
  localparam longint limit_cycles = 10 + sets + n_handshakes * 10;

  logic              clk;
  logic              rst;
  logic              req;
  tlb_pkg::tlb_req_t req_data;
  logic              ack;
  tlb_pkg::tlb_rsp_t rsp_data;

  integer seed;
  bit     after_sweep;

  // Model of the TLB contents and ranks.
  logic           m_valid [sets][ways];
  tlb_pkg::vpn_t  m_vpn   [sets][ways];
  tlb_pkg::asid_t m_asid  [sets][ways];
  tlb_pkg::pte_t  m_pte   [sets][ways];
  int             m_rank  [sets][ways];

  dtlb_top #(
    .sets (sets)
  ) dut_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp_data (rsp_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(limit_cycles * 100);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding.", limit_cycles);
    fail_run();
  end

  task automatic fail_run();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
      fail_run();
    end
  endtask

  function automatic tlb_pkg::vpn_t make_vpn(input logic [31:0] tag, input int set);
    return (tlb_pkg::vpn_t'(tag) << idx_bits) | tlb_pkg::vpn_t'(set);
  endfunction

  function automatic tlb_pkg::pte_t rand_pte();
    tlb_pkg::pte_t p;
    p = $random(seed);
    p.glob = 1'b0;  // Global entries only where a test asks for them.
    return p;
  endfunction

  task automatic model_reset();
    for (int s = 0; s < sets; s++) begin
      for (int k = 0; k < ways; k++) begin
        m_valid[s][k] = 1'b0;
        m_rank[s][k]  = k;  // Way k starts at rank k.
      end
    end
  endtask

  function automatic int find_way(input tlb_pkg::vpn_t vpn, input tlb_pkg::asid_t asid);
    int s;
    s = int'(vpn[idx_bits-1:0]);
    for (int k = 0; k < ways; k++) begin
      if (m_valid[s][k] && m_vpn[s][k] == vpn &&
          (m_asid[s][k] == asid || m_pte[s][k].glob)) begin
        return k;
      end
    end
    return -1;
  endfunction

  // The used way becomes the youngest. Ways younger than it age by one.
  task automatic touch(input int s, input int w);
    int old;
    old = m_rank[s][w];
    for (int k = 0; k < ways; k++) begin
      if (k == w) m_rank[s][k] = 0;
      else if (m_rank[s][k] < old) m_rank[s][k] = m_rank[s][k] + 1;
    end
  endtask

  task automatic model_apply(input tlb_pkg::tlb_req_t r, output tlb_pkg::tlb_rsp_t exp);
    int s;
    int w;
    s   = int'(r.vpn[idx_bits-1:0]);
    w   = find_way(r.vpn, r.asid);
    exp = '0;
    case (r.op)
      tlb_pkg::op_lookup: begin
        if (w >= 0) begin
          exp.hit = 1'b1;
          exp.way = 3'(w);
          exp.pte = m_pte[s][w];
          touch(s, w);
        end
      end
      tlb_pkg::op_fill: begin
        exp.hit = (w >= 0);
        if (w < 0) begin
          for (int k = 0; k < ways; k++) if (m_rank[s][k] == ways - 1) w = k;
        end
        m_valid[s][w] = 1'b1;
        m_vpn[s][w]   = r.vpn;
        m_asid[s][w]  = r.asid;
        m_pte[s][w]   = r.pte;
        exp.way       = 3'(w);
        exp.pte       = r.pte;
        touch(s, w);
      end
      default: begin
        if (w >= 0) begin  // Ranks stay as they are.
          exp.hit       = 1'b1;
          exp.way       = 3'(w);
          exp.pte       = m_pte[s][w];
          m_valid[s][w] = 1'b0;
        end
      end
    endcase
  endtask

  // One four-phase handshake. hold keeps req high for extra cycles after ack.
  task automatic transact(input string name, input tlb_pkg::tlb_req_t r, input int hold,
                          output tlb_pkg::tlb_rsp_t got);
    int waited;
    @(negedge clk);
    req      = 1'b1;
    req_data = r;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!ack && waited < ack_limit);
    assert (ack === 1'b1) else begin
      $display("No ack from the DUT within %0d cycles in test %s.", ack_limit, name);
      fail_run();
    end
    if (after_sweep) begin
      check_int({name, " latency"}, 4, waited);
    end else begin
      // The sweep takes one cycle per set before the first request can issue.
      assert (waited > sets) else begin
        $display("First request answered before the init sweep ended in test %s.", name);
        fail_run();
      end
    end
    got = rsp_data;
    repeat (hold) begin
      @(negedge clk);
      assert (ack === 1'b1 && rsp_data === got) else begin
        $display("ack or the response changed while req was held in test %s.", name);
        fail_run();
      end
    end
    req = 1'b0;
    @(negedge clk);
    assert (ack === 1'b0) else begin
      $display("ack did not drop one cycle after req fell in test %s.", name);
      fail_run();
    end
    after_sweep = 1'b1;
  endtask

  task automatic run_op(input string name, input tlb_pkg::tlb_op_e op,
                        input tlb_pkg::vpn_t vpn, input tlb_pkg::asid_t asid,
                        input tlb_pkg::pte_t pte, input int hold,
                        output tlb_pkg::tlb_rsp_t got);
    tlb_pkg::tlb_req_t r;
    tlb_pkg::tlb_rsp_t exp;
    r.op   = op;
    r.vpn  = vpn;
    r.asid = asid;
    r.pte  = pte;
    model_apply(r, exp);
    transact(name, r, hold, got);
    assert (got === exp) else begin
      $display("[FAIL] %s: expected hit=%0b way=%0d pte=%h, actual hit=%0b way=%0d pte=%h",
               name, exp.hit, exp.way, exp.pte, got.hit, got.way, got.pte);
      fail_run();
    end
  endtask

  task automatic test_reset_handshake();
    tlb_pkg::tlb_rsp_t got;
    run_op("reset_handshake", tlb_pkg::op_lookup, make_vpn($random(seed), 0), 12'h001,
           '0, 3, got);
  endtask

  task automatic test_fill_lookup();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::vpn_t     vpn [3];
    tlb_pkg::asid_t    asid;
    asid = $random(seed);
    for (int i = 0; i < 3; i++) begin
      vpn[i] = make_vpn($random(seed), 1);
      run_op("fill_empty_set", tlb_pkg::op_fill, vpn[i], asid, rand_pte(), 0, got);
      check_int("fill_empty_set way", 7 - i, int'(got.way));
    end
    for (int i = 0; i < 3; i++) begin
      run_op("lookup_filled", tlb_pkg::op_lookup, vpn[i], asid, '0, 0, got);
    end
    run_op("lookup_other_asid", tlb_pkg::op_lookup, vpn[0], asid ^ 12'h001, '0, 0, got);
  endtask

  task automatic test_global();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::vpn_t     vpn;
    tlb_pkg::pte_t     pte;
    vpn      = make_vpn($random(seed), 2);
    pte      = rand_pte();
    pte.glob = 1'b1;
    run_op("global_fill", tlb_pkg::op_fill, vpn, 12'h005, pte, 0, got);
    run_op("global_other_asid", tlb_pkg::op_lookup, vpn, 12'h009, '0, 0, got);
    run_op("global_same_asid", tlb_pkg::op_lookup, vpn, 12'h005, '0, 0, got);
  endtask

  task automatic test_lru_evict();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::vpn_t     vpn [9];
    int                second_way;
    second_way = 0;
    for (int i = 0; i < 9; i++) vpn[i] = make_vpn($random(seed), 3);
    for (int i = 0; i < 8; i++) begin
      run_op("lru_fill", tlb_pkg::op_fill, vpn[i], 12'h010, rand_pte(), 0, got);
      if (i == 1) second_way = int'(got.way);
    end
    run_op("lru_touch_first", tlb_pkg::op_lookup, vpn[0], 12'h010, '0, 0, got);
    run_op("lru_evict", tlb_pkg::op_fill, vpn[8], 12'h010, rand_pte(), 0, got);
    check_int("lru_evict way", second_way, int'(got.way));
    for (int i = 0; i < 9; i++) begin
      run_op("lru_after_evict", tlb_pkg::op_lookup, vpn[i], 12'h010, '0, 0, got);
    end
  endtask

  task automatic test_refill();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::vpn_t     vpn [3];
    int                old_way;
    for (int i = 0; i < 3; i++) begin
      vpn[i] = make_vpn($random(seed), 8);
      run_op("refill_setup", tlb_pkg::op_fill, vpn[i], 12'h020, rand_pte(), 0, got);
    end
    old_way = find_way(vpn[1], 12'h020);
    run_op("refill", tlb_pkg::op_fill, vpn[1], 12'h020, rand_pte(), 0, got);
    check_int("refill way", old_way, int'(got.way));
    for (int i = 0; i < 3; i++) begin
      run_op("refill_lookup", tlb_pkg::op_lookup, vpn[i], 12'h020, '0, 0, got);
    end
  endtask

  task automatic test_invalidate();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::vpn_t     vpn;
    int                old_way;
    // The oldest way of the full set 3 is invalidated. If its rank moved,
    // the next fill would pick another way.
    old_way = 0;
    for (int k = 0; k < ways; k++) begin
      if (m_rank[3][k] == ways - 1) begin
        old_way = k;
      end
    end
    vpn = m_vpn[3][old_way];
    run_op("inval_hit", tlb_pkg::op_inval, vpn, 12'h010, '0, 0, got);
    run_op("inval_then_lookup", tlb_pkg::op_lookup, vpn, 12'h010, '0, 0, got);
    run_op("inval_absent", tlb_pkg::op_inval, make_vpn($random(seed), 3), 12'h010, '0, 0, got);
    vpn = make_vpn($random(seed), 3);
    run_op("inval_ranks_kept", tlb_pkg::op_fill, vpn, 12'h010, rand_pte(), 0, got);
    check_int("inval_ranks_kept way", old_way, int'(got.way));
    run_op("inval_new_lookup", tlb_pkg::op_lookup, vpn, 12'h010, '0, 0, got);
  endtask

  // Small vpn and asid pools keep hits, refills and evictions frequent.
  task automatic test_random_mix();
    tlb_pkg::tlb_rsp_t got;
    tlb_pkg::tlb_op_e  op;
    tlb_pkg::vpn_t     vpn;
    tlb_pkg::asid_t    asid;
    for (int i = 0; i < n_random; i++) begin
      case ($unsigned($random(seed)) % 3)
        0: op = tlb_pkg::op_lookup;
        1: op = tlb_pkg::op_fill;
        default: op = tlb_pkg::op_inval;
      endcase
      vpn  = make_vpn(32'h00a0 + $unsigned($random(seed)) % 12,
                      4 + $unsigned($random(seed)) % 4);
      asid = 12'h001 + $unsigned($random(seed)) % 2;
      run_op("random_mix", op, vpn, asid, rand_pte(), 0, got);
    end
  endtask

  initial begin
    seed        = 32'heeec;
    after_sweep = 1'b0;
    rst         = 1'b1;
    req         = 1'b0;
    req_data    = '0;
    model_reset();
    repeat (10) begin
      @(negedge clk);
      assert (ack === 1'b0) else begin
        $display("ack was not low during reset.");
        fail_run();
      end
    end
    rst = 1'b0;
    test_reset_handshake();
    test_fill_lookup();
    test_global();
    test_lru_evict();
    test_refill();
    test_invalidate();
    test_random_mix();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
src/tlb_pkg.sv
src/tlb_set_ram.sv
src/tlb_way.sv
src/tlb_req_port.sv
src/tlb_lookup_stage.sv
src/tlb_update_stage.sv
src/dtlb_top.sv
sim/tb_dtlb.sv

//--- Bender.yml
package:
  name: dtlb

sources:
  - src/tlb_pkg.sv
  - src/tlb_set_ram.sv
  - src/tlb_way.sv
  - src/tlb_req_port.sv
  - src/tlb_lookup_stage.sv
  - src/tlb_update_stage.sv
  - src/dtlb_top.sv
  - target: simulation
    files:
      - sim/tb_dtlb.sv
